//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= filelist.f
RTL_TOP   ?= reset_detector_top
TB_TOP    ?= reset_detector_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o sim_$(TB_TOP)
	./$(BUILD_DIR)/sim_$(TB_TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
hw/spi_cfg_pkg.sv
hw/reset_evt_pkg.sv
hw/spi_cfg_receiver.sv
hw/reset_cfg_regs.sv
hw/reset_event_capture.sv
hw/reset_event_stream.sv
hw/reset_detector_top.sv
verification/reset_detector_tb.sv

//--- hw/reset_cfg_regs.sv
// Configuration registers decoding SPI frames into the source mask and clear strobes
`default_nettype none
`timescale 1ns/10ps

module reset_cfg_regs (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 frame_valid,
  input  logic [spi_cfg_pkg::spi_frame_w-1:0]  frame_data,
  output logic [reset_evt_pkg::num_sources-1:0] src_mask,
  output logic [reset_evt_pkg::num_sources-1:0] clear_req
);
  import spi_cfg_pkg::*;
  import reset_evt_pkg::*;

  spi_cmd_u cmd;

  assign cmd.raw = frame_data;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      src_mask  <= mask_reset_value;
      clear_req <= '0;
    end else begin
      clear_req <= '0;
      if (frame_valid) begin
        if (cmd.mask_cmd.op == op_mask_write) begin
          src_mask <= cmd.mask_cmd.mask;
        end else begin
          // One-cycle strobe into the capture block
          clear_req <= cmd.clear_cmd.clear;
        end
      end
    end
  end

  a_clear_follows_frame: assert property (
    @(posedge clk) disable iff (!rst_n) (|clear_req) |-> $past(frame_valid)
  );

endmodule

`default_nettype wire

//--- hw/reset_detector_top.sv
// Reset detector with SPI configuration and AXI-Stream event reporting
`default_nettype none
`timescale 1ns/10ps

module reset_detector_top #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 spi_cs,
  input  logic                                 spi_sck,
  input  logic                                 spi_mosi,
  input  logic [reset_evt_pkg::num_sources-1:0] reset_sources,
  output logic [reset_evt_pkg::stream_w-1:0]   m_axis_tdata,
  output logic                                 m_axis_tvalid,
  input  logic                                 m_axis_tready,
  output logic                                 m_axis_tlast
);
  import spi_cfg_pkg::*;
  import reset_evt_pkg::*;

  logic [spi_frame_w-1:0] frame_data;
  logic                   frame_valid;
  logic [num_sources-1:0] src_mask;
  logic [num_sources-1:0] clear_req;
  logic [num_sources-1:0] pending;
  logic                   take;

  spi_cfg_receiver #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_spi_rx (
    .clk         (clk),
    .rst_n       (rst_n),
    .spi_cs      (spi_cs),
    .spi_sck     (spi_sck),
    .spi_mosi    (spi_mosi),
    .frame_data  (frame_data),
    .frame_valid (frame_valid)
  );

  reset_cfg_regs u_cfg_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame_valid (frame_valid),
    .frame_data  (frame_data),
    .src_mask    (src_mask),
    .clear_req   (clear_req)
  );

  reset_event_capture #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_capture (
    .clk           (clk),
    .rst_n         (rst_n),
    .take          (take),
    .reset_sources (reset_sources),
    .src_mask      (src_mask),
    .clear_req     (clear_req),
    .pending       (pending)
  );

  reset_event_stream u_stream (
    .clk           (clk),
    .rst_n         (rst_n),
    .m_axis_tready (m_axis_tready),
    .pending       (pending),
    .take          (take),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tlast  (m_axis_tlast)
  );

endmodule

`default_nettype wire

//--- hw/reset_event_capture.sv
// Reset source capture with edge detection, masking and pending event bits
`default_nettype none
`timescale 1ns/10ps

module reset_event_capture #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 take,
  input  logic [reset_evt_pkg::num_sources-1:0] reset_sources,
  input  logic [reset_evt_pkg::num_sources-1:0] src_mask,
  input  logic [reset_evt_pkg::num_sources-1:0] clear_req,
  output logic [reset_evt_pkg::num_sources-1:0] pending
);
  import reset_evt_pkg::*;

  logic [SYNC_STAGES-1:0][num_sources-1:0] src_sync;
  logic [num_sources-1:0]                  src_s;
  logic [num_sources-1:0]                  src_prev;
  logic [num_sources-1:0]                  rise_en;
  logic [num_sources-1:0]                  kept;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      src_sync <= '0;
      src_prev <= '0;
    end else begin
      src_sync <= {src_sync[SYNC_STAGES-2:0], reset_sources};
      src_prev <= src_s;
    end
  end

  assign src_s = src_sync[SYNC_STAGES-1];

  // Only the low-to-high transition counts, a held source reports once
  assign rise_en = src_s & ~src_prev & src_mask;

  // A take empties everything loaded into the beat
  assign kept = take ? '0 : pending;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= '0;
    end else begin
      // Clear wins over an edge on the same bit
      pending <= (kept | rise_en) & ~clear_req;
    end
  end

endmodule

`default_nettype wire

//--- hw/reset_event_stream.sv
// AXI-Stream output stage holding the event beat and the sequence counter
`default_nettype none
`timescale 1ns/10ps

module reset_event_stream (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 m_axis_tready,
  input  logic [reset_evt_pkg::num_sources-1:0] pending,
  output logic                                 take,
  output logic [reset_evt_pkg::stream_w-1:0]   m_axis_tdata,
  output logic                                 m_axis_tvalid,
  output logic                                 m_axis_tlast
);
  import reset_evt_pkg::*;

  logic [seq_w-1:0]    seq_q;
  logic [stream_w-1:0] beat_q;

  // Load when the output slot is empty or being drained this cycle
  assign take = (|pending) && (!m_axis_tvalid || m_axis_tready);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_axis_tvalid <= 1'b0;
      seq_q         <= '0;
    end else if (take) begin
      m_axis_tvalid <= 1'b1;
      seq_q         <= seq_q + 1'b1;
    end else if (m_axis_tready) begin
      m_axis_tvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      beat_q <= {seq_q, pending};
    end
  end

  assign m_axis_tdata = beat_q;
  // Every packet is one beat
  assign m_axis_tlast = m_axis_tvalid;

  a_hold_while_stalled: assert property (
    @(posedge clk) disable iff (!rst_n)
      (m_axis_tvalid && !m_axis_tready) |=> (m_axis_tvalid && $stable(m_axis_tdata))
  );

  a_beat_has_events: assert property (
    @(posedge clk) disable iff (!rst_n)
      m_axis_tvalid |-> (m_axis_tdata[num_sources-1:0] != '0)
  );

endmodule

`default_nettype wire

//--- hw/reset_evt_pkg.sv
// Reset event sources and the layout of the streamed event word
`default_nettype none

package reset_evt_pkg;

  localparam int num_sources = 4;

  // Sequence number wraps after 16 beats
  localparam int seq_w = 4;

  // Stream word is {seq, event bits}, event bits in the low nibble
  localparam int stream_w = seq_w + num_sources;

  // All sources watched out of reset
  localparam logic [num_sources-1:0] mask_reset_value = '1;

endpackage

`default_nettype wire

//--- hw/spi_cfg_pkg.sv
// SPI configuration frame format and the command word decode
`default_nettype none

package spi_cfg_pkg;

  localparam int spi_frame_w = 8;
  // Payload field below the opcode and reserved bits
  localparam int spi_arg_w   = 4;
  localparam int spi_rsvd_w  = spi_frame_w - 1 - spi_arg_w;

  // Frame MSB selects the command
  typedef enum logic {
    op_mask_write = 1'b0,
    op_clear      = 1'b1
  } spi_op_e;

  typedef union packed {
    struct packed {
      spi_op_e               op;
      logic [spi_rsvd_w-1:0] rsvd;
      logic [spi_arg_w-1:0]  mask;
    } mask_cmd;
    struct packed {
      spi_op_e               op;
      logic [spi_rsvd_w-1:0] rsvd;
      logic [spi_arg_w-1:0]  clear;
    } clear_cmd;
    logic [spi_frame_w-1:0] raw;
  } spi_cmd_u;

endpackage

`default_nettype wire

//--- hw/spi_cfg_receiver.sv
// SPI frame receiver that oversamples the pins and emits whole 8-bit frames
`default_nettype none
`timescale 1ns/10ps

module spi_cfg_receiver #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               spi_cs,
  input  logic                               spi_sck,
  input  logic                               spi_mosi,
  output logic [spi_cfg_pkg::spi_frame_w-1:0] frame_data,
  output logic                               frame_valid
);
  import spi_cfg_pkg::*;

  localparam int cnt_w = $clog2(spi_frame_w + 1);
  localparam logic [cnt_w-1:0] frame_len = cnt_w'(spi_frame_w);
  localparam logic [cnt_w-1:0] last_bit  = cnt_w'(spi_frame_w - 1);

  logic [SYNC_STAGES-1:0] cs_sync;
  logic [SYNC_STAGES-1:0] sck_sync;
  logic [SYNC_STAGES-1:0] mosi_sync;
  logic                   sck_prev;
  logic                   cs_s;
  logic                   sck_s;
  logic                   mosi_s;
  logic                   shift_en;
  logic [cnt_w-1:0]       bit_cnt;
  logic [spi_frame_w-1:0] shift_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cs_sync   <= '1;
      sck_sync  <= '0;
      mosi_sync <= '0;
      sck_prev  <= 1'b0;
    end else begin
      cs_sync   <= {cs_sync[SYNC_STAGES-2:0], spi_cs};
      sck_sync  <= {sck_sync[SYNC_STAGES-2:0], spi_sck};
      mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], spi_mosi};
      sck_prev  <= sck_s;
    end
  end

  assign cs_s   = cs_sync[SYNC_STAGES-1];
  assign sck_s  = sck_sync[SYNC_STAGES-1];
  assign mosi_s = mosi_sync[SYNC_STAGES-1];

  // Rising sck inside the cs window, bits past the eighth are ignored
  assign shift_en = !cs_s && sck_s && !sck_prev && (bit_cnt < frame_len);

  // Count clears while cs is high, so a short frame never completes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt     <= '0;
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= 1'b0;
      if (cs_s) begin
        bit_cnt <= '0;
      end else if (shift_en) begin
        bit_cnt     <= bit_cnt + 1'b1;
        frame_valid <= (bit_cnt == last_bit);
      end
    end
  end

  // MSB first
  always_ff @(posedge clk) begin
    if (shift_en) begin
      shift_q <= {shift_q[spi_frame_w-2:0], mosi_s};
    end
  end

  assign frame_data = shift_q;

  a_single_frame_strobe: assert property (
    @(posedge clk) disable iff (!rst_n) frame_valid |=> !frame_valid
  );

endmodule

`default_nettype wire

//--- verification/reset_detector_tb.sv
// Reset detector testbench driving SPI frames and source pulses and checking streamed beats
`default_nettype none
`timescale 1ns/10ps

module reset_detector_tb;
  import spi_cfg_pkg::*;
  import reset_evt_pkg::*;

  localparam int spi_half       = 4;
  localparam int timeout_cycles = 200;
  localparam int do_edge        = 0;
  localparam int do_mask        = 1;
  localparam int do_clear       = 2;
  localparam int do_load        = 3;

  logic                   clk;
  logic                   rst_n;
  logic                   spi_cs;
  logic                   spi_sck;
  logic                   spi_mosi;
  logic                   m_axis_tready;
  logic [num_sources-1:0] reset_sources;
  logic [stream_w-1:0]    m_axis_tdata;
  logic                   m_axis_tvalid;
  logic                   m_axis_tlast;

  logic [num_sources-1:0] model_mask;
  logic [num_sources-1:0] model_pending;
  logic [seq_w-1:0]       model_seq;
  logic [stream_w-1:0]    exp_q[$];
  string                  test_name;
  integer                 seed;
  int                     beat_cnt;
  int                     pushed_cnt;
  int                     mismatch_cnt;
  int                     error_cnt;

  reset_detector_top #(.SYNC_STAGES(2)) DUT (.*);

  always #2 clk = ~clk;

  // Model of mask, pending bits and sequence number
  // A load returns {seq, pending}
  function logic [stream_w-1:0] ref_model(input int op, input logic [num_sources-1:0] bits);
    logic [stream_w-1:0] beat;
    beat = '0;
    case (op)
      do_edge:  model_pending = model_pending | (bits & model_mask);
      do_mask:  model_mask = bits;
      do_clear: model_pending = model_pending & ~bits;
      default: begin
        beat = {model_seq, model_pending};
        model_seq = model_seq + 4'd1;
        model_pending = '0;
      end
    endcase
    return beat;
  endfunction

  function automatic logic [spi_frame_w-1:0] make_frame(input spi_op_e op,
                                                        input logic [3:0] bits);
    spi_cmd_u cmd;
    cmd.raw = '0;
    cmd.mask_cmd.op = op;
    if (op == op_mask_write) begin
      cmd.mask_cmd.mask = bits;
    end else begin
      cmd.clear_cmd.clear = bits;
    end
    return cmd.raw;
  endfunction

  task automatic step(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic expect_load();
    exp_q.push_back(ref_model(do_load, '0));
    pushed_cnt++;
  endtask

  task automatic pulse_sources(input logic [num_sources-1:0] bits, input bit load_now);
    void'(ref_model(do_edge, bits));
    if (load_now) begin
      expect_load();
    end
    reset_sources = bits;
    step(3);
    reset_sources = '0;
    step(3);
  endtask

  // Waits for tvalid, or with drain set until every expected beat is taken
  task automatic wait_for(input bit drain);
    int cycles;
    cycles = 0;
    while ((drain ? beat_cnt < pushed_cnt : !m_axis_tvalid) && cycles < timeout_cycles) begin
      step(1);
      cycles++;
    end
    if (drain ? beat_cnt < pushed_cnt : !m_axis_tvalid) begin
      $display("Timeout in test %s: %s", test_name,
               drain ? "expected beat was never delivered" : "tvalid never rose");
      $display("Regression failed");
      $finish;
    end
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
      step(1);
      assert (!m_axis_tvalid) else begin
        $display("Test %s: tvalid rose although no enabled source changed", test_name);
        error_cnt++;
      end
    end
  endtask

  // Masked-out pulse keeps tvalid low for the whole window
  task automatic pulse_masked(input logic [num_sources-1:0] bits);
    void'(ref_model(do_edge, bits));
    reset_sources = bits;
    expect_quiet(3);
    reset_sources = '0;
    expect_quiet(20);
  endtask

  // Mode 0 frame sent MSB first with sck toggling every spi_half clocks
  task automatic spi_send(input logic [spi_frame_w-1:0] frame, input int nbits);
    spi_cs = 1'b0;
    step(spi_half);
    repeat (nbits) begin
      spi_mosi = frame[spi_frame_w-1];
      frame = {frame[spi_frame_w-2:0], 1'b0};
      step(spi_half);
      spi_sck = 1'b1;
      step(spi_half);
      spi_sck = 1'b0;
    end
    step(spi_half);
    spi_cs = 1'b1;
    step(2 * spi_half);
  endtask

  // Handshake seen mid-cycle completes at the next rising edge
  always @(negedge clk) begin
    logic [stream_w-1:0] exp_beat;
    if (rst_n && m_axis_tvalid && m_axis_tready) begin
      assert (exp_q.size() > 0) else begin
        $display("Test %s: beat 0x%02h arrived with none expected", test_name, m_axis_tdata);
        error_cnt++;
      end
      if (exp_q.size() > 0) begin
        exp_beat = exp_q.pop_front();
        assert (m_axis_tdata == exp_beat) else begin
          $display("MISMATCH test %s expected 0x%02h actual 0x%02h",
                   test_name, exp_beat, m_axis_tdata);
          mismatch_cnt++;
        end
      end
      assert (m_axis_tlast) else begin
        $display("Test %s: tlast was low on a valid beat", test_name);
        error_cnt++;
      end
      beat_cnt++;
    end
  end

  initial begin
    int src;
    int gap;
    clk = 1'b0;
    rst_n = 1'b0;
    spi_cs = 1'b1;
    spi_sck = 1'b0;
    spi_mosi = 1'b0;
    m_axis_tready = 1'b1;
    reset_sources = '0;
    model_mask = mask_reset_value;
    model_pending = '0;
    model_seq = '0;
    seed = 68814;
    beat_cnt = 0;
    pushed_cnt = 0;
    mismatch_cnt = 0;
    error_cnt = 0;
    test_name = "reset";
    step(8);
    rst_n = 1'b1;
    step(2);
    assert (!m_axis_tvalid) else begin
      $display("Test %s: tvalid high right after reset", test_name);
      error_cnt++;
    end

    test_name = "single_sources";
    for (int i = 0; i < num_sources; i++) begin
      pulse_sources(4'b0001 << i, 1'b1);
      wait_for(1'b1);
    end
    for (int i = 0; i < 4; i++) begin
      src = $random(seed) & 3;
      gap = $random(seed) & 3;
      m_axis_tready = (gap == 0);
      pulse_sources(4'b0001 << src, 1'b1);
      step(gap);
      m_axis_tready = 1'b1;
      wait_for(1'b1);
    end

    test_name = "mask_write";
    spi_send(make_frame(op_mask_write, 4'b0101), spi_frame_w);
    void'(ref_model(do_mask, 4'b0101));
    pulse_masked(4'b0010);
    pulse_sources(4'b0100, 1'b1);
    wait_for(1'b1);
    spi_send(make_frame(op_mask_write, 4'b1111), spi_frame_w);
    void'(ref_model(do_mask, 4'b1111));

    test_name = "stall_merge";
    m_axis_tready = 1'b0;
    pulse_sources(4'b0001, 1'b1);
    wait_for(1'b0);
    pulse_sources(4'b0010, 1'b0);
    pulse_sources(4'b0100, 1'b0);
    expect_load();
    m_axis_tready = 1'b1;
    wait_for(1'b1);

    test_name = "clear_stalled";
    m_axis_tready = 1'b0;
    pulse_sources(4'b0001, 1'b1);
    wait_for(1'b0);
    pulse_sources(4'b0110, 1'b0);
    spi_send(make_frame(op_clear, 4'b0011), spi_frame_w);
    void'(ref_model(do_clear, 4'b0011));
    expect_load();
    m_axis_tready = 1'b1;
    wait_for(1'b1);

    test_name = "short_frame";
    spi_send(make_frame(op_mask_write, 4'b0000), 5);
    pulse_sources(4'b0001, 1'b1);
    wait_for(1'b1);
    spi_send(make_frame(op_mask_write, 4'b1000), spi_frame_w);
    void'(ref_model(do_mask, 4'b1000));
    pulse_masked(4'b0001);
    pulse_sources(4'b1000, 1'b1);
    wait_for(1'b1);

    step(10);
    assert (exp_q.size() == 0) else begin
      $display("Beats still expected at the end of the run: %0d", exp_q.size());
      error_cnt++;
    end
    $display("Checked %0d beats: %0d mismatches, %0d other errors",
             beat_cnt, mismatch_cnt, error_cnt);
    if (mismatch_cnt == 0 && error_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
